/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // ======================================================================
    // Data widths
    // ======================================================================
    typedef logic [7:0]  byteT;          // One memory byte
    typedef logic [15:0] wordT;          // General and data register value

    localparam int DefaultAddressWidth = 8;

    // ======================================================================
    // Opcodes that execute; everything else is a no-op
    // ======================================================================
    localparam logic [5:0] OpcodeLdal  = 6'h1E;
    localparam logic [5:0] OpcodeSta   = 6'h20;
    localparam logic [5:0] OpcodeLddrl = 6'h21;
    localparam logic [5:0] OpcodeStdr  = 6'h23;
    localparam logic [5:0] OpcodeStrim = 6'h24;

    // Phase bit positions in the one-hot sequencer
    localparam int PhaseCount = 7;
    localparam int PhaseT0 = 0;          // Fetch low byte
    localparam int PhaseT1 = 1;          // Fetch high byte
    localparam int PhaseT2 = 2;          // Decode
    localparam int PhaseT3 = 3;
    localparam int PhaseT4 = 4;
    localparam int PhaseT5 = 5;
    localparam int PhaseT6 = 6;

    // Instruction word, memory format or register format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [1:0] regSel;          // R1 to R4
            logic [7:0] address;         // Direct address or offset
        } memForm;
        struct packed {
            logic [5:0] opcode;
            logic [2:0] destReg;
            logic [2:0] srcReg1;
            logic [2:0] srcReg2;
            logic       unused;
        } regForm;
    } instructionT;

    // Memory address source
    localparam logic AddrSrcPc = 1'b0;
    localparam logic AddrSrcAr = 1'b1;

    // AR load source
    localparam logic [1:0] ArLoadAddress = 2'd0;  // Address field
    localparam logic [1:0] ArLoadData    = 2'd1;  // DR low byte
    localparam logic [1:0] ArLoadOffset  = 2'd2;  // AR plus address field

endpackage

`default_nettype wire

/* verilog/cpuControlIf.sv */
`default_nettype none

interface cpuControlIf;

    logic [3:0]   regLoad;           // One-hot over R1 to R4
    logic [1:0]   regRead;
    logic         pcIncrement;
    logic         pcLoad;
    logic         arIncrement;
    logic         arLoad;
    logic [1:0]   arLoadSource;
    logic         addressSource;     // PC or AR onto the memory address
    logic         byteLane;          // 0 low byte, 1 high byte
    logic         drLoadLow;
    logic         drLoadHigh;
    logic         memWrite;
    logic         memSelect;
    cpuPkg::byteT immediate;         // Operand byte for PC and AR

    modport sequencer (
        output regLoad, regRead, pcIncrement, pcLoad, arIncrement, arLoad,
               arLoadSource, addressSource, byteLane, drLoadLow, drLoadHigh,
               memWrite, memSelect, immediate
    );

    modport registers (input regLoad, regRead);

    modport addressing (
        input pcIncrement, pcLoad, arIncrement, arLoad, arLoadSource, immediate
    );

    modport memory (
        input addressSource, byteLane, drLoadLow, drLoadHigh, memWrite, memSelect
    );

endinterface

`default_nettype wire

/* verilog/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  logic                Clock,
    input  logic                Reset,
    cpuControlIf.sequencer      ctrl,
    input  cpuPkg::byteT        readByte,
    input  cpuPkg::wordT        drValue
);

    localparam logic [cpuPkg::PhaseCount-1:0] FirstPhase = 1 << cpuPkg::PhaseT0;

    logic [cpuPkg::PhaseCount-1:0] phase;   // One-hot T0..T6
    cpuPkg::instructionT           ir;
    logic [5:0]                    opcode;
    logic                          lastPhase; // Return to T0 at next edge

    assign opcode = ir.memForm.opcode;

    // ======================================================================
    // Instruction register and phase sequencer
    // ======================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase <= FirstPhase;
            ir    <= '0;
        end else begin
            if (phase[cpuPkg::PhaseT0]) ir[7:0]  <= readByte;
            if (phase[cpuPkg::PhaseT1]) ir[15:8] <= readByte;
            if (lastPhase)
                phase <= FirstPhase;
            else
                phase <= {phase[cpuPkg::PhaseCount-2:0], phase[cpuPkg::PhaseCount-1]};
        end
    end

    // ======================================================================
    // Control decode
    // ======================================================================
    always_comb begin
        ctrl.regLoad       = '0;
        ctrl.regRead       = ir.memForm.regSel;
        ctrl.pcIncrement   = 1'b0;
        ctrl.pcLoad        = 1'b0;
        ctrl.arIncrement   = 1'b0;
        ctrl.arLoad        = 1'b0;
        ctrl.arLoadSource  = cpuPkg::ArLoadAddress;
        ctrl.addressSource = cpuPkg::AddrSrcPc;
        ctrl.byteLane      = 1'b0;
        ctrl.drLoadLow     = 1'b0;
        ctrl.drLoadHigh    = 1'b0;
        ctrl.memWrite      = 1'b0;
        ctrl.memSelect     = 1'b0;
        ctrl.immediate     = ir.memForm.address;
        lastPhase          = 1'b0;

        case (1'b1)
            phase[cpuPkg::PhaseT0], phase[cpuPkg::PhaseT1]: begin
                ctrl.memSelect   = 1'b1;          // Fetch from PC
                ctrl.pcIncrement = 1'b1;
            end
            phase[cpuPkg::PhaseT2]: begin
                // Decode only, IR is complete
            end
            phase[cpuPkg::PhaseT3]: begin
                case (opcode)
                    cpuPkg::OpcodeLdal, cpuPkg::OpcodeSta: begin
                        ctrl.arLoad = 1'b1;        // AR from address field
                    end
                    cpuPkg::OpcodeLddrl: begin
                        ctrl.memSelect     = 1'b1;
                        ctrl.addressSource = cpuPkg::AddrSrcAr;
                        ctrl.drLoadLow     = 1'b1;
                        ctrl.arIncrement   = 1'b1;
                    end
                    cpuPkg::OpcodeStdr: begin
                        ctrl.immediate = drValue[7:0]; // PC takes DR low byte
                        case (ir.regForm.destReg)
                            3'd0: ctrl.pcLoad = 1'b1;
                            3'd1: ;                    // Former SP slot
                            3'd2, 3'd3: begin
                                ctrl.arLoad       = 1'b1;
                                ctrl.arLoadSource = cpuPkg::ArLoadData;
                            end
                            default: ctrl.regLoad = 4'b0001 << ir.regForm.destReg[1:0];
                        endcase
                        lastPhase = 1'b1;
                    end
                    cpuPkg::OpcodeStrim: begin
                        ctrl.arLoad       = 1'b1;
                        ctrl.arLoadSource = cpuPkg::ArLoadOffset;
                    end
                    default: lastPhase = 1'b1;     // Unused opcode
                endcase
            end
            phase[cpuPkg::PhaseT4], phase[cpuPkg::PhaseT5]: begin
                ctrl.memSelect     = 1'b1;
                ctrl.addressSource = cpuPkg::AddrSrcAr;
                ctrl.byteLane      = phase[cpuPkg::PhaseT5];
                ctrl.arIncrement   = phase[cpuPkg::PhaseT4];
                case (opcode)
                    cpuPkg::OpcodeLdal: begin
                        ctrl.drLoadLow  = phase[cpuPkg::PhaseT4];
                        ctrl.drLoadHigh = phase[cpuPkg::PhaseT5];
                    end
                    cpuPkg::OpcodeLddrl: begin
                        ctrl.drLoadHigh  = 1'b1;   // Only reached in T4
                        ctrl.arIncrement = 1'b0;
                        lastPhase        = 1'b1;
                    end
                    cpuPkg::OpcodeSta, cpuPkg::OpcodeStrim: begin
                        ctrl.memWrite = 1'b1;
                        lastPhase     = phase[cpuPkg::PhaseT5];
                    end
                    default: lastPhase = 1'b1;
                endcase
            end
            phase[cpuPkg::PhaseT6]: begin
                ctrl.regLoad = 4'b0001 << ir.memForm.regSel; // LDAL writeback
                lastPhase    = 1'b1;
            end
            default: lastPhase = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic           Clock,
    input  logic           Reset,
    cpuControlIf.registers ctrl,
    input  cpuPkg::wordT   drValue,
    output cpuPkg::wordT   readData
);

    cpuPkg::wordT registers [4];   // R1 to R4

    // ======================================================================
    // Register write from DR
    // ======================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 4; i++) begin
                registers[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (ctrl.regLoad[i]) registers[i] <= drValue;
            end
        end
    end

    // Read port toward the memory write lane
    assign readData = registers[ctrl.regRead];

endmodule

`default_nettype wire

/* verilog/addressUnit.sv */
`default_nettype none

module addressUnit #(
    parameter int AddressWidth = cpuPkg::DefaultAddressWidth
) (
    input  logic                    Clock,
    input  logic                    Reset,
    cpuControlIf.addressing         ctrl,
    input  cpuPkg::wordT            drValue,
    output logic [AddressWidth-1:0] pc,
    output logic [AddressWidth-1:0] ar
);

    logic [AddressWidth-1:0] operand;
    logic [AddressWidth-1:0] arNext;

    assign operand = AddressWidth'(ctrl.immediate);

    always_comb begin
        case (ctrl.arLoadSource)
            cpuPkg::ArLoadData:   arNext = AddressWidth'(drValue[7:0]);
            cpuPkg::ArLoadOffset: arNext = ar + operand;  // Wraps at address width
            default:              arNext = operand;
        endcase
    end

    // ======================================================================
    // PC and AR
    // ======================================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
            ar <= '0;
        end else begin
            if (ctrl.pcLoad)
                pc <= operand;        // DR low byte during STDR
            else if (ctrl.pcIncrement)
                pc <= pc + 1'b1;

            if (ctrl.arLoad)
                ar <= arNext;
            else if (ctrl.arIncrement)
                ar <= ar + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/memoryPort.sv */
`default_nettype none

module memoryPort #(
    parameter int AddressWidth = cpuPkg::DefaultAddressWidth
) (
    input  logic                    Clock,
    input  logic                    Reset,
    cpuControlIf.memory             ctrl,
    input  logic [AddressWidth-1:0] pc,
    input  logic [AddressWidth-1:0] ar,
    input  cpuPkg::wordT            readData,
    output logic [AddressWidth-1:0] MemAddress,
    output cpuPkg::byteT            MemWriteData,
    input  cpuPkg::byteT            MemReadData,
    output logic                    MemWrite,
    output logic                    MemSelect,
    output cpuPkg::wordT            drValue,
    output cpuPkg::byteT            readByte
);

    cpuPkg::wordT dr;

    assign MemAddress   = (ctrl.addressSource == cpuPkg::AddrSrcAr) ? ar : pc;
    assign MemWriteData = ctrl.byteLane ? readData[15:8] : readData[7:0]; // Low byte first
    assign MemWrite     = ctrl.memWrite;
    assign MemSelect    = ctrl.memSelect;
    assign readByte     = MemReadData;    // Instruction bytes go straight to IR
    assign drValue      = dr;

    // Data register, filled one byte per read
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dr <= '0;
        end else begin
            if (ctrl.drLoadLow)  dr[7:0]  <= MemReadData;
            if (ctrl.drLoadHigh) dr[15:8] <= MemReadData;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpuSystem.sv */
`default_nettype none

module cpuSystem #(
    parameter int AddressWidth = cpuPkg::DefaultAddressWidth
) (
    input  logic                    Clock,
    input  logic                    Reset,
    output logic [AddressWidth-1:0] MemAddress,
    output cpuPkg::byteT            MemWriteData,
    input  cpuPkg::byteT            MemReadData,
    output logic                    MemWrite,
    output logic                    MemSelect
);

    cpuPkg::wordT            readData;   // Selected register
    cpuPkg::wordT            drValue;
    cpuPkg::byteT            readByte;
    logic [AddressWidth-1:0] pc;
    logic [AddressWidth-1:0] ar;

    cpuControlIf ctrlBus ();

    // ======================================================================
    // Sequencer and datapath
    // ======================================================================
    controlUnit sequencer (
        .Clock, .Reset, .ctrl(ctrlBus.sequencer), .readByte, .drValue
    );

    registerFile registers (
        .Clock, .Reset, .ctrl(ctrlBus.registers), .drValue, .readData
    );

    addressUnit #(.AddressWidth(AddressWidth)) addressing (
        .Clock, .Reset, .ctrl(ctrlBus.addressing), .drValue, .pc, .ar
    );

    memoryPort #(.AddressWidth(AddressWidth)) memory (
        .Clock, .Reset, .ctrl(ctrlBus.memory), .pc, .ar, .readData,
        .MemAddress, .MemWriteData, .MemReadData, .MemWrite, .MemSelect,
        .drValue, .readByte
    );

endmodule

`default_nettype wire

/* test/cpuSystem_chk.sv */
`default_nettype none

module cpuSystem_chk #(
    parameter int AddressWidth = cpuPkg::DefaultAddressWidth
) (
    input logic                          Clock,
    input logic                          Reset,
    input logic [cpuPkg::PhaseCount-1:0] phase,
    input logic [AddressWidth-1:0]       MemAddress,
    input logic                          MemWrite,
    input logic                          MemSelect
);

    int failureCount = 0;   // Assertion failures so far

    phaseOneHot: assert property (@(posedge Clock) disable iff (Reset) $onehot(phase))
        else begin
            failureCount++;
            $error("phase register is not one-hot: %b", phase);
        end

    writeNeedsSelect: assert property (@(posedge Clock) disable iff (Reset)
                                       MemWrite |-> MemSelect)
        else begin
            failureCount++;
            $error("MemWrite high while MemSelect is low");
        end

    addressKnown: assert property (@(posedge Clock) disable iff (Reset)
                                   MemSelect |-> !$isunknown(MemAddress))
        else begin
            failureCount++;
            $error("MemAddress has unknown bits during an access");
        end

    // Fetch and decode never write
    noWriteEarly: assert property (@(posedge Clock)
                                   (Reset || |phase[cpuPkg::PhaseT2:cpuPkg::PhaseT0]) |-> !MemWrite)
        else begin
            failureCount++;
            $error("MemWrite high during reset or T0 to T2");
        end

endmodule

bind cpuSystem cpuSystem_chk #(.AddressWidth(AddressWidth)) protocolChecks (
    .Clock, .Reset, .phase(sequencer.phase), .MemAddress, .MemWrite, .MemSelect
);

`default_nettype wire

/* test/cpuSystemTb.sv */
`default_nettype none

module cpuSystemTb;

    localparam int AddressWidth     = cpuPkg::DefaultAddressWidth;
    localparam int InstructionTotal = 300;
    localparam int TimeoutCycles    = InstructionTotal * 7 + 100;  // Longest instruction is 7

    typedef logic [AddressWidth-1:0] addressT;
    typedef struct packed {
        logic         select;
        logic         write;
        addressT      address;
        cpuPkg::byteT data;
    } accessT;

    logic         Clock = 1'b0;
    logic         Reset = 1'b1;
    addressT      MemAddress;
    cpuPkg::byteT MemWriteData;
    cpuPkg::byteT MemReadData;
    logic         MemWrite;
    logic         MemSelect;

    cpuPkg::byteT memory [2**AddressWidth];      // Seen by the DUT
    cpuPkg::byteT modelMem [2**AddressWidth];    // Model copy
    addressT      modelPc;
    addressT      modelAr;
    cpuPkg::wordT modelRegs [4];                 // R1 to R4
    cpuPkg::wordT modelDr;
    accessT       expected [$];                  // One entry per clock cycle
    logic [31:0]  rngState = 32'h7d61;
    int           cycleCount = 0;
    int           checkCount = 0;
    int           errorCount = 0;
    int           instructionCount = 0;

    cpuSystem dut (
        .Clock, .Reset, .MemAddress, .MemWriteData, .MemReadData, .MemWrite, .MemSelect
    );

    always #5 Clock = ~Clock;
    always @(posedge Clock) cycleCount <= cycleCount + 1;

    // ======================================================================
    // Memory model
    // ======================================================================
    assign MemReadData = memory[MemAddress];     // Combinational read
    always @(posedge Clock) begin
        if (MemSelect && MemWrite) memory[MemAddress] <= MemWriteData;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cpuPkg::instructionT randomInstruction();
        cpuPkg::instructionT insn;
        logic [5:0]          unusedOp;
        rngState = xorshift(rngState);
        insn     = rngState[15:0];               // Random fields in both forms
        unusedOp = rngState[21:16];
        if (unusedOp inside {cpuPkg::OpcodeLdal, cpuPkg::OpcodeSta, cpuPkg::OpcodeLddrl,
                             cpuPkg::OpcodeStdr, cpuPkg::OpcodeStrim})
            unusedOp = 6'h3F;
        case (rngState[31:24] % 6)
            0: insn.memForm.opcode = cpuPkg::OpcodeLdal;
            1: insn.memForm.opcode = cpuPkg::OpcodeSta;
            2: insn.memForm.opcode = cpuPkg::OpcodeLddrl;
            3: insn.regForm.opcode = cpuPkg::OpcodeStdr;
            4: insn.memForm.opcode = cpuPkg::OpcodeStrim;
            default: insn.memForm.opcode = unusedOp;
        endcase
        return insn;
    endfunction

    // ======================================================================
    // Instruction-set model
    // ======================================================================
    function automatic cpuPkg::byteT expectRead(input addressT address);
        expected.push_back(accessT'{1'b1, 1'b0, address, modelMem[address]});
        return modelMem[address];
    endfunction

    function automatic void expectWrite(input addressT address, input cpuPkg::byteT data);
        expected.push_back(accessT'{1'b1, 1'b1, address, data});
        modelMem[address] = data;
    endfunction

    function automatic void expectIdle();
        expected.push_back(accessT'{1'b0, 1'b0, '0, '0});
    endfunction

    // Low byte at AR, high byte at the next address
    function automatic void storeRegister(input logic [1:0] sel);
        expectWrite(modelAr, modelRegs[sel][7:0]);
        modelAr = modelAr + 1'b1;
        expectWrite(modelAr, modelRegs[sel][15:8]);
    endfunction

    function automatic void modelInstruction();
        cpuPkg::instructionT insn;
        insn[7:0]  = expectRead(modelPc);
        modelPc    = modelPc + 1'b1;
        insn[15:8] = expectRead(modelPc);
        modelPc    = modelPc + 1'b1;
        expectIdle();                            // Decode
        case (insn.memForm.opcode)
            cpuPkg::OpcodeLdal: begin
                expectIdle();
                modelAr       = insn.memForm.address;
                modelDr[7:0]  = expectRead(modelAr);
                modelAr       = modelAr + 1'b1;
                modelDr[15:8] = expectRead(modelAr);
                expectIdle();                    // Register writeback
                modelRegs[insn.memForm.regSel] = modelDr;
            end
            cpuPkg::OpcodeSta: begin
                expectIdle();
                modelAr = insn.memForm.address;
                storeRegister(insn.memForm.regSel);
            end
            cpuPkg::OpcodeLddrl: begin
                modelDr[7:0]  = expectRead(modelAr);
                modelAr       = modelAr + 1'b1;
                modelDr[15:8] = expectRead(modelAr);
            end
            cpuPkg::OpcodeStdr: begin
                expectIdle();
                case (insn.regForm.destReg)
                    3'd0: modelPc = modelDr[7:0];
                    3'd1: ;                      // Old SP slot
                    3'd2, 3'd3: modelAr = modelDr[7:0];
                    default: modelRegs[insn.regForm.destReg - 3'd4] = modelDr;
                endcase
            end
            cpuPkg::OpcodeStrim: begin
                expectIdle();
                modelAr = modelAr + insn.memForm.address;
                storeRegister(insn.memForm.regSel);
            end
            default: expectIdle();
        endcase
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic checkAddress(input addressT actual, input addressT expectedValue);
        checkCount++;
        if (actual !== expectedValue) begin
            errorCount++;
            $display("mismatch MemAddress: got %h, expected %h", actual, expectedValue);
        end
    endtask

    task automatic checkByte(input string name, input cpuPkg::byteT actual,
                             input cpuPkg::byteT expectedValue);
        checkCount++;
        if (actual !== expectedValue) begin
            errorCount++;
            $display("mismatch %s: got %h, expected %h", name, actual, expectedValue);
        end
    endtask

    task automatic checkStrobe(input string name, input logic actual,
                               input logic expectedValue);
        checkCount++;
        if (actual !== expectedValue) begin
            errorCount++;
            $display("mismatch %s: got %h, expected %h", name, actual, expectedValue);
        end
    endtask

    task automatic checkCycle();
        accessT want;
        want = expected.pop_front();
        checkStrobe("MemSelect", MemSelect, want.select);
        checkStrobe("MemWrite", MemWrite, want.write);
        if (want.select) begin
            checkAddress(MemAddress, want.address);
            if (want.write)
                checkByte("MemWriteData", MemWriteData, want.data);
            else
                checkByte("MemReadData", MemReadData, want.data);
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        cpuPkg::instructionT insn;
        for (int i = 0; i < 2**AddressWidth; i += 2) begin
            insn          = randomInstruction();
            memory[i]     = insn[7:0];           // Low byte first
            memory[i + 1] = insn[15:8];
        end
        modelMem  = memory;
        modelPc   = '0;
        modelAr   = '0;
        modelDr   = '0;
        modelRegs = '{default: '0};
        repeat (8) @(negedge Clock);
        Reset = 1'b0;
        while (instructionCount < InstructionTotal || expected.size() != 0) begin
            if (expected.size() == 0) begin
                modelInstruction();
                instructionCount++;
            end
            checkCycle();
            @(negedge Clock);
        end
        errorCount += dut.protocolChecks.failureCount;
        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        wait (cycleCount >= TimeoutCycles);
        $display("Timeout: run did not finish within %0d cycles, checks %0d, errors %0d",
                 TimeoutCycles, checkCount, errorCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/cpuPkg.sv
verilog/cpuControlIf.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/addressUnit.sv
verilog/memoryPort.sv
verilog/cpuSystem.sv
test/cpuSystem_chk.sv
test/cpuSystemTb.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  - verilog/cpuPkg.sv
  - verilog/cpuControlIf.sv
  - verilog/controlUnit.sv
  - verilog/registerFile.sv
  - verilog/addressUnit.sv
  - verilog/memoryPort.sv
  - verilog/cpuSystem.sv
  - target: test
    files:
      - test/cpuSystem_chk.sv
      - test/cpuSystemTb.sv
